// ==== rtl/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	localparam int tag_bits = 3;

	typedef logic [tag_bits-1:0] lc3b_tag;

	// One enable bit per byte lane, bit 1 is the high byte.
	typedef logic [1:0] lc3b_mem_wmask;

	typedef struct packed {
		logic valid;
		lc3b_tag tag;
		lc3b_word data;
	} cdb_t;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_word addr;
		lc3b_word wdata;
		lc3b_mem_wmask byte_enable;
		lc3b_tag dest;
	} mem_req_t;

endpackage

`default_nettype wire

// ==== rtl/dispatch_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface dispatch_if;
	import lc3b_types::*;

	lc3b_opcode opcode;
	lc3b_word vbase;
	logic vbase_valid;
	lc3b_tag qbase;
	lc3b_word vsrc;
	logic vsrc_valid;
	lc3b_tag qsrc;
	lc3b_word offset;
	lc3b_tag dest;

	modport source (output opcode, vbase, vbase_valid, qbase, vsrc, vsrc_valid, qsrc,
		offset, dest);

	modport sink (input opcode, vbase, vbase_valid, qbase, vsrc, vsrc_valid, qsrc,
		offset, dest);

endinterface

`default_nettype wire

// ==== rtl/issue_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface issue_if #(parameter int num_entries = 4);

	localparam int idx_bits = (num_entries > 1) ? $clog2(num_entries) : 1;

	logic start;
	logic [idx_bits-1:0] head_idx;
	logic done;
	// High while the port holds a load.
	logic is_load;

	modport ctrl (output start, head_idx, input done, is_load);

	modport port (input start, head_idx, output done, is_load);

endinterface

`default_nettype wire

// ==== rtl/ls_station_entry.sv ====
`timescale 1ns/100ps
`default_nettype none

module ls_station_entry
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic alloc,
	input logic free,
	dispatch_if.sink disp,
	input lc3b_types::cdb_t cdb_in,
	output logic valid,
	output logic ready,
	output lc3b_types::mem_req_t req
);
	import lc3b_types::*;

	logic busy;
	logic base_ok;
	logic src_ok;
	lc3b_opcode opcode_q;
	lc3b_word base_q;
	lc3b_word src_q;
	lc3b_word offset_q;
	lc3b_tag qbase_q;
	lc3b_tag qsrc_q;
	lc3b_tag dest_q;
	lc3b_word addr;
	logic is_store;
	logic snoop_base;
	logic snoop_src;

	assign is_store = (opcode_q == op_str) | (opcode_q == op_stb);

	// Broadcasts in the dispatch cycle are not seen.
	assign snoop_base = cdb_in.valid & (cdb_in.tag == qbase_q) & busy & ~base_ok;
	assign snoop_src = cdb_in.valid & (cdb_in.tag == qsrc_q) & busy & ~src_ok & is_store;

	always_ff @(posedge clk)
	begin
		if (rst | flush)
		begin
			busy <= 1'b0;
			base_ok <= 1'b0;
			src_ok <= 1'b0;
		end
		else if (alloc)
		begin
			busy <= 1'b1;
			base_ok <= disp.vbase_valid;
			src_ok <= disp.vsrc_valid;
		end
		else
		begin
			if (free)
				busy <= 1'b0;
			if (snoop_base)
				base_ok <= 1'b1;
			if (snoop_src)
				src_ok <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (alloc)
		begin
			opcode_q <= disp.opcode;
			base_q <= disp.vbase;
			qbase_q <= disp.qbase;
			src_q <= disp.vsrc;
			qsrc_q <= disp.qsrc;
			offset_q <= disp.offset;
			dest_q <= disp.dest;
		end
		else
		begin
			if (snoop_base)
				base_q <= cdb_in.data;
			if (snoop_src)
				src_q <= cdb_in.data;
		end
	end

	assign addr = base_q + offset_q;

	assign valid = busy;
	assign ready = busy & base_ok & (~is_store | src_ok);

	always_comb
	begin
		req.opcode = opcode_q;
		req.addr = addr;
		req.dest = dest_q;
		req.wdata = src_q;
		req.byte_enable = 2'b11;
		if (opcode_q == op_stb)
		begin
			// Low source byte goes to the lane picked by addr bit 0.
			req.wdata = addr[0] ? {src_q[7:0], 8'h00} : {8'h00, src_q[7:0]};
			req.byte_enable = addr[0] ? 2'b10 : 2'b01;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/ls_order_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module ls_order_ctrl #(parameter int num_entries = 4)
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic we,
	input logic [num_entries-1:0] valid_vec,
	input logic [num_entries-1:0] ready_vec,
	output logic [num_entries-1:0] alloc_vec,
	output logic [num_entries-1:0] free_vec,
	output logic full,
	issue_if.ctrl iss
);

	localparam int idx_bits = (num_entries > 1) ? $clog2(num_entries) : 1;
	localparam int cnt_bits = idx_bits + 1;

	logic [idx_bits-1:0] head;
	logic [idx_bits-1:0] tail;
	logic [cnt_bits-1:0] count;
	logic in_flight;
	logic stale;
	logic bcast_wait;
	logic do_alloc;
	logic do_free;

	assign full = (count == cnt_bits'(num_entries));
	assign do_alloc = we & ~full;
	// A response for an access issued before a flush frees nothing.
	assign do_free = iss.done & ~stale;

	assign alloc_vec = do_alloc ? (num_entries'(1) << tail) : '0;
	assign free_vec = do_free ? (num_entries'(1) << head) : '0;

	assign iss.head_idx = head;
	assign iss.start = ~flush & ~in_flight & valid_vec[head] & ready_vec[head];

	always_ff @(posedge clk)
	begin
		if (rst | flush)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			if (do_alloc)
				tail <= tail + 1'b1;
			if (do_free)
				head <= head + 1'b1;
			if (do_alloc & ~do_free)
				count <= count + 1'b1;
			else if (do_free & ~do_alloc)
				count <= count - 1'b1;
		end
	end

	// Port tracking survives a flush, the access still runs to its response.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			in_flight <= 1'b0;
			stale <= 1'b0;
			bcast_wait <= 1'b0;
		end
		else
		begin
			bcast_wait <= iss.done & iss.is_load;
			// A load keeps the port one more cycle for its CDB beat.
			if (iss.start)
				in_flight <= 1'b1;
			else if ((iss.done & ~iss.is_load) | bcast_wait)
				in_flight <= 1'b0;
			if (iss.done)
				stale <= 1'b0;
			else if (flush & in_flight & ~bcast_wait)
				stale <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dmem_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module dmem_port #(parameter int num_entries = 4)
(
	input logic clk,
	input logic rst,
	input logic flush,
	input lc3b_types::mem_req_t reqs [num_entries],
	input lc3b_types::lc3b_word dmem_rdata,
	input logic dmem_resp,
	issue_if.port iss,
	output lc3b_types::lc3b_word dmem_addr,
	output lc3b_types::lc3b_word dmem_wdata,
	output logic dmem_read,
	output logic dmem_write,
	output lc3b_types::lc3b_mem_wmask dmem_byte_enable,
	output lc3b_types::cdb_t cdb_out
);
	import lc3b_types::*;

	mem_req_t req_q;
	mem_req_t sel_req;
	logic sel_load;
	logic active;
	logic flushed;
	logic cdb_valid_q;
	lc3b_tag cdb_tag_q;
	lc3b_word cdb_data_q;
	lc3b_word load_data;

	assign sel_req = reqs[iss.head_idx];
	assign sel_load = (sel_req.opcode == op_ldr) | (sel_req.opcode == op_ldb);

	assign active = dmem_read | dmem_write;
	assign iss.done = dmem_resp & active;
	assign iss.is_load = dmem_read;

	assign dmem_addr = req_q.addr;
	assign dmem_wdata = req_q.wdata;
	assign dmem_byte_enable = req_q.byte_enable;

	always_comb
	begin
		if (req_q.opcode == op_ldb)
			load_data = req_q.addr[0] ? {8'h00, dmem_rdata[15:8]} : {8'h00, dmem_rdata[7:0]};
		else
			load_data = dmem_rdata;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dmem_read <= 1'b0;
			dmem_write <= 1'b0;
			flushed <= 1'b0;
			cdb_valid_q <= 1'b0;
		end
		else
		begin
			cdb_valid_q <= iss.done & dmem_read & ~flushed & ~flush;
			if (iss.start)
			begin
				dmem_read <= sel_load;
				dmem_write <= ~sel_load;
			end
			else if (dmem_resp)
			begin
				dmem_read <= 1'b0;
				dmem_write <= 1'b0;
			end
			if (iss.done)
				flushed <= 1'b0;
			else if (flush & active)
				flushed <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (iss.start)
			req_q <= sel_req;
		if (iss.done)
		begin
			cdb_tag_q <= req_q.dest;
			cdb_data_q <= load_data;
		end
	end

	assign cdb_out = '{valid: cdb_valid_q, tag: cdb_tag_q, data: cdb_data_q};

endmodule

`default_nettype wire

// ==== rtl/ld_str_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module ld_str_unit #(parameter int num_entries = 4)
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic we,
	input lc3b_types::lc3b_opcode opcode,
	input lc3b_types::lc3b_word vbase,
	input logic vbase_valid,
	input lc3b_types::lc3b_tag qbase,
	input lc3b_types::lc3b_word vsrc,
	input logic vsrc_valid,
	input lc3b_types::lc3b_tag qsrc,
	input lc3b_types::lc3b_word offset,
	input lc3b_types::lc3b_tag dest,
	output logic full,
	input logic cdb_in_valid,
	input lc3b_types::lc3b_tag cdb_in_tag,
	input lc3b_types::lc3b_word cdb_in_data,
	output logic cdb_out_valid,
	output lc3b_types::lc3b_tag cdb_out_tag,
	output lc3b_types::lc3b_word cdb_out_data,
	output lc3b_types::lc3b_word dmem_addr,
	output logic dmem_read,
	output logic dmem_write,
	output lc3b_types::lc3b_word dmem_wdata,
	output lc3b_types::lc3b_mem_wmask dmem_byte_enable,
	input lc3b_types::lc3b_word dmem_rdata,
	input logic dmem_resp
);
	import lc3b_types::*;

	logic [num_entries-1:0] valid_vec;
	logic [num_entries-1:0] ready_vec;
	logic [num_entries-1:0] alloc_vec;
	logic [num_entries-1:0] free_vec;
	mem_req_t reqs [num_entries];
	cdb_t cdb_in;
	cdb_t cdb_out;

	dispatch_if disp ();
	issue_if #(.num_entries(num_entries)) iss ();

	assign disp.opcode = opcode;
	assign disp.vbase = vbase;
	assign disp.vbase_valid = vbase_valid;
	assign disp.qbase = qbase;
	assign disp.vsrc = vsrc;
	assign disp.vsrc_valid = vsrc_valid;
	assign disp.qsrc = qsrc;
	assign disp.offset = offset;
	assign disp.dest = dest;

	assign cdb_in = '{valid: cdb_in_valid, tag: cdb_in_tag, data: cdb_in_data};
	assign cdb_out_valid = cdb_out.valid;
	assign cdb_out_tag = cdb_out.tag;
	assign cdb_out_data = cdb_out.data;

	ls_order_ctrl #(.num_entries(num_entries)) ctrl_inst (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.we(we),
		.valid_vec(valid_vec),
		.ready_vec(ready_vec),
		.alloc_vec(alloc_vec),
		.free_vec(free_vec),
		.full(full),
		.iss(iss.ctrl)
	);

	for (genvar i = 0; i < num_entries; i++)
	begin : g_entry
		ls_station_entry entry_inst (
			.clk(clk),
			.rst(rst),
			.flush(flush),
			.alloc(alloc_vec[i]),
			.free(free_vec[i]),
			.disp(disp.sink),
			.cdb_in(cdb_in),
			.valid(valid_vec[i]),
			.ready(ready_vec[i]),
			.req(reqs[i])
		);
	end

	dmem_port #(.num_entries(num_entries)) port_inst (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.reqs(reqs),
		.dmem_rdata(dmem_rdata),
		.dmem_resp(dmem_resp),
		.iss(iss.port),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_read(dmem_read),
		.dmem_write(dmem_write),
		.dmem_byte_enable(dmem_byte_enable),
		.cdb_out(cdb_out)
	);

endmodule

`default_nettype wire

// ==== bench/dmem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module dmem_model
(
	input logic clk,
	input logic rst,
	input logic read,
	input logic write,
	input lc3b_types::lc3b_word addr,
	input lc3b_types::lc3b_word wdata,
	input lc3b_types::lc3b_mem_wmask byte_enable,
	output lc3b_types::lc3b_word rdata,
	output logic resp
);
	import lc3b_types::*;

	lc3b_word mem [256];
	logic busy;
	logic [1:0] wait_cnt;
	logic [31:0] lat_state;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Word i holds a pattern built from every bit of its index.
	initial
	begin
		for (int i = 0; i < 256; i++)
			mem[i] = {8'(i) ^ 8'h5a, ~8'(i)};
	end

	always @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			resp <= 1'b0;
			lat_state <= 32'd44;
		end
		else if (resp)
			resp <= 1'b0;
		else if (busy)
		begin
			if (wait_cnt == 2'd0)
			begin
				busy <= 1'b0;
				resp <= 1'b1;
				rdata <= mem[addr[8:1]];
				if (write & byte_enable[0])
					mem[addr[8:1]][7:0] <= wdata[7:0];
				if (write & byte_enable[1])
					mem[addr[8:1]][15:8] <= wdata[15:8];
			end
			else
				wait_cnt <= wait_cnt - 2'd1;
		end
		else if (read | write)
		begin
			// Latency of 1 to 4 cycles.
			busy <= 1'b1;
			wait_cnt <= lat_state[1:0];
			lat_state <= xorshift32(lat_state);
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_ld_str_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ld_str_unit;
	import lc3b_types::*;

	localparam int num_entries = 4;
	localparam int max_cycles = 3000;

	typedef struct {
		lc3b_opcode op;
		lc3b_word addr;
		lc3b_word wdata;
		lc3b_mem_wmask be;
		lc3b_tag dest;
	} exp_t;

	logic clk;
	logic rst;
	logic flush;
	logic we;
	lc3b_opcode opcode;
	lc3b_word vbase;
	logic vbase_valid;
	lc3b_tag qbase;
	lc3b_word vsrc;
	logic vsrc_valid;
	lc3b_tag qsrc;
	lc3b_word offset;
	lc3b_tag dest;
	logic full;
	logic cdb_in_valid;
	lc3b_tag cdb_in_tag;
	lc3b_word cdb_in_data;
	logic cdb_out_valid;
	lc3b_tag cdb_out_tag;
	lc3b_word cdb_out_data;
	lc3b_word dmem_addr;
	logic dmem_read;
	logic dmem_write;
	lc3b_word dmem_wdata;
	lc3b_mem_wmask dmem_byte_enable;
	lc3b_word dmem_rdata;
	logic dmem_resp;

	exp_t exp_q [$];
	exp_t cur;
	logic cur_flushed;
	logic was_access;
	logic access;
	logic cdb_due;
	lc3b_tag due_tag;
	lc3b_word due_data;
	lc3b_word mirror [256];
	lc3b_word word;
	int cycles;
	logic [31:0] rng;
	string test_name;
	lc3b_opcode ops [4] = '{op_ldr, op_ldb, op_str, op_stb};

	ld_str_unit #(.num_entries(num_entries)) ld_str_unit_inst (.*);

	dmem_model mem_inst (
		.clk(clk),
		.rst(rst),
		.read(dmem_read),
		.write(dmem_write),
		.addr(dmem_addr),
		.wdata(dmem_wdata),
		.byte_enable(dmem_byte_enable),
		.rdata(dmem_rdata),
		.resp(dmem_resp)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_eq(input string what, input int exp, input int act);
		assert (exp == act)
		else
			stop_run($sformatf("Error in %s, %s: expected %h, actual %h",
				test_name, what, exp, act));
	endtask

	task automatic dispatch(input lc3b_opcode op, input lc3b_word base, input logic bv,
		input lc3b_tag qb, input lc3b_word src, input logic sv, input lc3b_tag qs,
		input lc3b_word off, input lc3b_tag d);
		exp_t e;
		lc3b_word a;
		while (full)
		begin
			@(posedge clk);
			#1;
		end
		a = base + off;
		e.op = op;
		e.addr = a;
		e.dest = d;
		e.wdata = src;
		e.be = 2'b11;
		if (op == op_stb)
		begin
			e.wdata = a[0] ? {src[7:0], 8'h00} : {8'h00, src[7:0]};
			e.be = a[0] ? 2'b10 : 2'b01;
		end
		// A pending operand is driven with junk, so an early access shows up.
		we = 1'b1;
		opcode = op;
		vbase = bv ? base : 16'h0bad;
		vbase_valid = bv;
		qbase = qb;
		vsrc = sv ? src : 16'h0bad;
		vsrc_valid = sv;
		qsrc = qs;
		offset = off;
		dest = d;
		exp_q.push_back(e);
		@(posedge clk);
		#1;
		we = 1'b0;
	endtask

	task automatic cdb_beat(input lc3b_tag t, input lc3b_word data);
		cdb_in_valid = 1'b1;
		cdb_in_tag = t;
		cdb_in_data = data;
		@(posedge clk);
		#1;
		cdb_in_valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0 || dmem_read || dmem_write || cdb_due || cdb_out_valid)
		begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= max_cycles)
			stop_run($sformatf("Timeout after %0d cycles in test %s", cycles, test_name));
	end

	// Reference scoreboard that follows the port at every edge.
	always @(posedge clk)
	begin
		if (rst)
		begin
			was_access = 1'b0;
			cdb_due = 1'b0;
			cur_flushed = 1'b0;
		end
		else
		begin
			if (cdb_due)
			begin
				assert (cdb_out_valid)
				else
					stop_run("A load result did not appear on cdb_out");
				check_eq("cdb_out tag", due_tag, cdb_out_tag);
				check_eq("cdb_out data", due_data, cdb_out_data);
			end
			else
			begin
				assert (!cdb_out_valid)
				else
					stop_run("cdb_out carried a beat that no load produced");
			end
			cdb_due = 1'b0;
			access = dmem_read | dmem_write;
			if (access && !was_access)
			begin
				assert (exp_q.size() > 0)
				else
					stop_run("A memory access started with no operation waiting for it");
				cur = exp_q.pop_front();
				cur_flushed = 1'b0;
				check_eq("access is a read", (cur.op == op_ldr) || (cur.op == op_ldb),
					dmem_read);
				check_eq("address", cur.addr, dmem_addr);
				if (dmem_write)
				begin
					check_eq("write data", cur.wdata, dmem_wdata);
					check_eq("byte enable", cur.be, dmem_byte_enable);
				end
			end
			if (flush)
			begin
				exp_q.delete();
				if (access)
					cur_flushed = 1'b1;
			end
			if (access && dmem_resp)
			begin
				word = mirror[cur.addr[8:1]];
				if (dmem_read)
				begin
					cdb_due = !cur_flushed;
					due_tag = cur.dest;
					due_data = word;
					if (cur.op == op_ldb)
						due_data = cur.addr[0] ? {8'h00, word[15:8]} : {8'h00, word[7:0]};
				end
				else
				begin
					if (cur.be[0])
						mirror[cur.addr[8:1]][7:0] = cur.wdata[7:0];
					if (cur.be[1])
						mirror[cur.addr[8:1]][15:8] = cur.wdata[15:8];
				end
			end
			was_access = access && !dmem_resp;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		(dmem_read && !dmem_resp) |=> (dmem_read && $stable(dmem_addr)))
	else
		stop_run("dmem_read dropped or its address moved before the response");

	assert property (@(posedge clk) disable iff (rst)
		(dmem_write && !dmem_resp) |=> (dmem_write && $stable(dmem_addr)
		&& $stable(dmem_wdata) && $stable(dmem_byte_enable)))
	else
		stop_run("dmem_write dropped or its request moved before the response");

	assert property (@(posedge clk) disable iff (rst) !(dmem_read && dmem_write))
	else
		stop_run("dmem_read and dmem_write were high together");

	assert property (@(posedge clk) disable iff (rst) cdb_out_valid |=> !cdb_out_valid)
	else
		stop_run("cdb_out stayed valid for more than one cycle");

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		flush = 1'b0;
		we = 1'b0;
		opcode = op_ldr;
		vbase = '0;
		vbase_valid = 1'b0;
		qbase = '0;
		vsrc = '0;
		vsrc_valid = 1'b0;
		qsrc = '0;
		offset = '0;
		dest = '0;
		cdb_in_valid = 1'b0;
		cdb_in_tag = '0;
		cdb_in_data = '0;
		cycles = 0;
		rng = 32'd44;
		test_name = "reset";
		for (int i = 0; i < 256; i++)
			mirror[i] = {8'(i) ^ 8'h5a, ~8'(i)};
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		check_eq("full", 0, full);
		check_eq("dmem_read", 0, dmem_read);
		check_eq("dmem_write", 0, dmem_write);
		check_eq("cdb_out_valid", 0, cdb_out_valid);

		test_name = "stores";
		dispatch(op_str, 16'h0040, 1, 0, 16'hbeef, 1, 0, 16'h0004, 0);
		dispatch(op_stb, 16'h0041, 1, 0, 16'h12a5, 1, 0, 16'h0000, 0);
		dispatch(op_stb, 16'h0050, 1, 0, 16'h3477, 1, 0, 16'h0000, 0);
		wait_idle();

		test_name = "loads";
		dispatch(op_ldr, 16'h0040, 1, 0, 0, 1, 0, 16'h0004, 1);
		dispatch(op_ldb, 16'h0041, 1, 0, 0, 1, 0, 16'h0000, 2);
		dispatch(op_ldb, 16'h0050, 1, 0, 0, 1, 0, 16'h0000, 3);
		wait_idle();

		test_name = "operand wakeup";
		dispatch(op_ldr, 16'h0080, 0, 5, 0, 1, 0, 16'h0002, 4);
		repeat (3)
		begin
			cdb_beat(2, 16'h1111);
			check_eq("read before base", 0, dmem_read);
		end
		cdb_beat(5, 16'h0080);
		// The store must find the port idle, so only its source holds it back.
		wait_idle();
		dispatch(op_str, 16'h0090, 1, 0, 16'h7777, 0, 6, 16'h0000, 0);
		cdb_beat(1, 16'h2222);
		check_eq("write before source", 0, dmem_write);
		cdb_beat(6, 16'h7777);
		wait_idle();

		test_name = "program order";
		dispatch(op_ldb, 16'h00a1, 0, 7, 0, 1, 0, 16'h0000, 5);
		dispatch(op_str, 16'h00b0, 1, 0, 16'h4321, 1, 0, 16'h0000, 0);
		repeat (4)
		begin
			@(posedge clk);
			#1;
			check_eq("younger store first", 0, dmem_write);
		end
		cdb_beat(7, 16'h00a1);
		wait_idle();

		test_name = "occupancy";
		for (int i = 0; i < num_entries; i++)
			dispatch(op_ldr, 16'h0100 + 16'(i * 2), 0, 3'(i + 1), 0, 1, 0, 0, 3'(i));
		check_eq("full", 1, full);
		we = 1'b1;
		opcode = op_str;
		vbase = 16'h0002;
		vbase_valid = 1'b1;
		vsrc = 16'hffff;
		vsrc_valid = 1'b1;
		@(posedge clk);
		#1;
		we = 1'b0;
		check_eq("full after write while full", 1, full);
		cdb_beat(1, 16'h0100);
		while (full)
		begin
			@(posedge clk);
			#1;
		end
		for (int i = 1; i < num_entries; i++)
			cdb_beat(3'(i + 1), 16'h0100 + 16'(i * 2));
		wait_idle();

		test_name = "flush";
		dispatch(op_ldr, 16'h0020, 1, 0, 0, 1, 0, 16'h0000, 6);
		dispatch(op_ldr, 16'h0030, 0, 3, 0, 1, 0, 16'h0000, 7);
		dispatch(op_stb, 16'h0031, 0, 4, 16'h00ff, 1, 0, 16'h0000, 0);
		while (!dmem_read)
		begin
			@(posedge clk);
			#1;
		end
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
		cdb_beat(3, 16'h0030);
		cdb_beat(4, 16'h0031);
		wait_idle();
		dispatch(op_str, 16'h0060, 1, 0, 16'h5a5a, 1, 0, 16'h0000, 0);
		wait_idle();

		test_name = "random";
		for (int i = 0; i < 40; i++)
		begin
			rng = xorshift32(rng);
			opcode = ops[rng[1:0]];
			rng = xorshift32(rng);
			vbase = {8'h00, rng[7:0]};
			rng = xorshift32(rng);
			vsrc = rng[15:0];
			rng = xorshift32(rng);
			offset = {8'h00, rng[7:0]};
			dispatch(opcode, vbase, 1, 0, vsrc, 1, 0, offset, 3'(i));
		end
		wait_idle();

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/lc3b_types.sv
rtl/dispatch_if.sv
rtl/issue_if.sv
rtl/ls_station_entry.sv
rtl/ls_order_ctrl.sv
rtl/dmem_port.sv
rtl/ld_str_unit.sv
bench/dmem_model.sv
bench/tb_ld_str_unit.sv

// ==== Bender.yml ====
package:
  name: ld_str_unit

sources:
  - rtl/lc3b_types.sv
  - rtl/dispatch_if.sv
  - rtl/issue_if.sv
  - rtl/ls_station_entry.sv
  - rtl/ls_order_ctrl.sv
  - rtl/dmem_port.sv
  - rtl/ld_str_unit.sv
  - target: test
    files:
      - bench/dmem_model.sv
      - bench/tb_ld_str_unit.sv
